// ==== nd_board_pkg.sv ====
// Shared bus, data and RAM widths, board page number
// and the 64-bit microword layout
package nd_board_pkg;

  // ******************************
  // Bus and memory geometry
  // ******************************
  localparam int BD_WIDTH       = 24;                  // ND bus address/data lines
  localparam int DATA_WIDTH     = 16;                  // Data word on BD 15:0
  localparam int RAM_ADDR_WIDTH = 8;                   // Word address from BD 7:0
  localparam int RAM_DEPTH      = 2 ** RAM_ADDR_WIDTH; // 256 words
  localparam int PAGE_WIDTH     = 5;                   // Decode on BD 23:19

  localparam logic [PAGE_WIDTH-1:0] RAM_BASE_PAGE = 5'd3; // Page that selects this board

  typedef logic [BD_WIDTH-1:0]       bd_word_t;   // Backplane word, true polarity
  typedef logic [DATA_WIDTH-1:0]     data_word_t; // Memory data word
  typedef logic [RAM_ADDR_WIDTH-1:0] ram_addr_t;  // RAM word address

  // ******************************
  // Microword layout
  // ******************************
  // Top bit first, so the struct maps straight onto csbits 63:0
  typedef struct packed {
    logic [8:0]  alui;   // 63:55 ALU instruction
    logic [8:0]  rsvd0;  // 54:46
    logic [1:0]  alum;   // 45:44 ALU mode
    logic [1:0]  mis;    // 43:42 Misc field
    logic [4:0]  idbs;   // 41:37 IDB source
    logic [4:0]  comm;   // 36:32 Command
    logic [3:0]  rsvd1;  // 31:28
    logic [1:0]  delay;  // 27:26
    logic [1:0]  rsvd2;  // 25:24
    logic        second; // 23 Condition select
    logic        loop;   // 22 Loop flag
    logic        dly;    // 21 Delay flag
    logic [20:0] rsvd3;  // 20:0
  } mic_word_t;

endpackage

// ==== mem_req_if.sv ====
// Four-phase req/ack memory request between the bus slave and the RAM
`timescale 1ns/10ps

interface mem_req_if import nd_board_pkg::*; ();

  logic       req;   // Request, held until ack seen
  logic       ack;   // Acknowledge, held until req drops
  logic       write; // 1 = write, 0 = read
  ram_addr_t  addr;  // Word address
  data_word_t wdata; // Write data
  data_word_t rdata; // Read data, valid while ack high

  // Bus slave side
  modport requester (
    output req, write, addr, wdata,
    input  ack, rdata
  );

  // RAM side
  modport responder (
    input  req, write, addr, wdata,
    output ack, rdata
  );

endinterface

// ==== micro_word_reg.sv ====
// Microinstruction register, field split-out and the clocked MIS latch
`timescale 1ns/10ps

module micro_word_reg import nd_board_pkg::*; (
  input  logic      s_clk,
  input  logic      reset,
  input  mic_word_t csbits,  // Control store word
  output logic [8:0] csalui, // ALU instruction
  output logic [1:0] csalum, // ALU mode
  output logic [4:0] csidbs, // IDB source
  output logic [4:0] cscomm, // Command
  output logic [1:0] csdelay,
  output logic [2:0] csflags, // {second, loop, dly}
  output logic [1:0] mis      // MIS, one stage behind the fields
);

  // ******************************
  // Microinstruction register
  // ******************************
  mic_word_t mic_q; // Current microinstruction
  logic [1:0] mis_q; // Board MIS latch

  always_ff @(posedge s_clk)
  begin
    if (reset)
    begin
      mic_q <= '0;
    end
    else
    begin
      mic_q <= csbits; // New word every clock
    end
  end

  // Second stage clocks only the MIS field
  always_ff @(posedge s_clk)
  begin
    if (reset)
    begin
      mis_q <= '0;
    end
    else
    begin
      mis_q <= mic_q.mis; // Lags the register by one cycle
    end
  end

  // ******************************
  // Field split-out
  // ******************************
  assign csalui  = mic_q.alui;
  assign csalum  = mic_q.alum;
  assign csidbs  = mic_q.idbs;
  assign cscomm  = mic_q.comm;
  assign csdelay = mic_q.delay;
  assign csflags = {mic_q.second, mic_q.loop, mic_q.dly}; // Sequencer flags
  assign mis     = mis_q;

endmodule

// ==== nd_bus_slave.sv ====
// ND bus slave with address latch, page decode, data-phase FSM
// and BDRY/read-data return onto the active-low bus
`timescale 1ns/10ps

module nd_bus_slave import nd_board_pkg::*; (
  input  logic         s_clk,
  input  logic         reset,
  input  bd_word_t     bd_n_in,     // Inverted address/data from master
  input  logic         bapr_n_in,   // Address present
  input  logic         bdap_n_in,   // Write data present
  input  logic         binput_n_in, // Read strobe
  output bd_word_t     bd_n_out,    // Inverted read data, ones when idle
  output logic         bdry_n_out,  // Data ready
  mem_req_if.requester mem
);

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_respond,
    st_release
  } slave_state_t;

  slave_state_t          state;
  logic                  apr_q;   // Address present, true polarity
  logic                  dap_q;   // Write strobe, true polarity
  logic                  inp_q;   // Read strobe, true polarity
  bd_word_t              bd_q;    // Bus word, true polarity
  logic [PAGE_WIDTH-1:0] page_q;  // Latched page
  ram_addr_t             addr_q;  // Latched word address
  logic                  wr_q;    // Current cycle is a write
  data_word_t            wdata_q; // Write data to RAM
  data_word_t            rdata_q; // Read word held for the bus
  logic                  hit;
  logic                  strobe_act;
  logic                  load_req;
  logic                  load_rd;
  logic                  bus_busy;

  // ******************************
  // Bus input registers
  // ******************************
  always_ff @(posedge s_clk)
  begin
    if (reset)
    begin
      apr_q <= 1'b0;
      dap_q <= 1'b0;
      inp_q <= 1'b0;
    end
    else
    begin
      apr_q <= ~bapr_n_in;
      dap_q <= ~bdap_n_in;
      inp_q <= ~binput_n_in;
    end
  end

  always_ff @(posedge s_clk)
  begin
    bd_q <= ~bd_n_in; // Data sampled with the strobe
    if (!bapr_n_in && !apr_q) // First edge of the address phase
    begin
      page_q <= ~bd_n_in[BD_WIDTH-1 -: PAGE_WIDTH];
      addr_q <= ~bd_n_in[RAM_ADDR_WIDTH-1:0];
    end
  end

  assign hit        = apr_q && (page_q == RAM_BASE_PAGE); // Off-page cycles are ignored
  assign strobe_act = dap_q || inp_q;
  assign load_req   = (state == st_idle) && hit && strobe_act;
  assign load_rd    = (state == st_request) && mem.ack;

  // ******************************
  // Data-phase FSM
  // ******************************
  always_ff @(posedge s_clk)
  begin
    if (reset)
    begin
      state <= st_idle;
      wr_q  <= 1'b0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          if (load_req)
          begin
            state <= st_request;
            wr_q  <= dap_q; // Write wins if both strobes low
          end
        end
        st_request:
        begin
          if (mem.ack)
          begin
            state <= st_respond;
          end
        end
        st_respond:
        begin
          if (!strobe_act)
          begin
            state <= st_release; // Master let go, drop req
          end
        end
        default:
        begin
          if (!mem.ack)
          begin
            state <= st_idle; // Ack low, next strobe allowed
          end
        end
      endcase
    end
  end

  always_ff @(posedge s_clk)
  begin
    if (load_req)
    begin
      wdata_q <= bd_q[DATA_WIDTH-1:0];
    end
    if (load_rd)
    begin
      rdata_q <= mem.rdata; // Held stable through back-pressure
    end
  end

  // ******************************
  // Memory request and bus return
  // ******************************
  assign mem.req   = (state == st_request) || (state == st_respond);
  assign mem.write = wr_q;
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata_q;

  assign bus_busy   = (state == st_respond) || (state == st_release);
  assign bdry_n_out = ~bus_busy;
  assign bd_n_out   = (bus_busy && !wr_q) ?
                      {{(BD_WIDTH-DATA_WIDTH){1'b1}}, ~rdata_q} : '1;

endmodule

// ==== onboard_ram.sv ====
// Onboard word RAM answering four-phase requests
`timescale 1ns/10ps

module onboard_ram import nd_board_pkg::*; (
  input  logic         s_clk,
  input  logic         reset,
  mem_req_if.responder mem
);

  data_word_t mem_array [RAM_DEPTH]; // 256 x 16 store
  data_word_t rdata_q;               // Read word, stable while ack high
  logic       ack_q;
  logic       take;                  // New request seen this edge

  assign take = mem.req && !ack_q;

  // ******************************
  // Handshake
  // ******************************
  always_ff @(posedge s_clk)
  begin
    if (reset)
    begin
      ack_q <= 1'b0;
    end
    else if (take)
    begin
      ack_q <= 1'b1; // One cycle after req seen
    end
    else if (!mem.req && ack_q)
    begin
      ack_q <= 1'b0; // Req gone, close the cycle
    end
  end

  // ******************************
  // Array access
  // ******************************
  always_ff @(posedge s_clk)
  begin
    if (take)
    begin
      if (mem.write)
      begin
        mem_array[mem.addr] <= mem.wdata;
      end
      else
      begin
        rdata_q <= mem_array[mem.addr]; // Same edge as ack rise
      end
    end
  end

  assign mem.ack   = ack_q;
  assign mem.rdata = rdata_q;

endmodule

// ==== nd_cpu_board.sv ====
// CPU board top level with microword path, ND bus slave and onboard RAM
`timescale 1ns/10ps

module nd_cpu_board import nd_board_pkg::*; (
  input  logic                s_clk,
  input  logic                reset,

  // Control store
  input  logic [63:0]         csbits,

  // ND bus, active low
  input  logic [BD_WIDTH-1:0] bd_n_in,
  input  logic                bapr_n_in,
  input  logic                bdap_n_in,
  input  logic                binput_n_in,
  output logic [BD_WIDTH-1:0] bd_n_out,
  output logic                bdry_n_out,

  // Microword fields
  output logic [8:0]          csalui,
  output logic [1:0]          csalum,
  output logic [4:0]          csidbs,
  output logic [4:0]          cscomm,
  output logic [1:0]          csdelay,
  output logic [2:0]          csflags,
  output logic [1:0]          mis
);

  // ******************************
  // Microinstruction path
  // ******************************
  micro_word_reg u_micro_word_reg (
    .s_clk   (s_clk),
    .reset   (reset),
    .csbits  (csbits),  // Raw word into the struct
    .csalui  (csalui),
    .csalum  (csalum),
    .csidbs  (csidbs),
    .cscomm  (cscomm),
    .csdelay (csdelay),
    .csflags (csflags),
    .mis     (mis)      // Clocked MIS
  );

  // ******************************
  // ND bus slave and RAM
  // ******************************
  mem_req_if mem_bus (); // Slave to RAM handshake

  nd_bus_slave u_nd_bus_slave (
    .s_clk       (s_clk),
    .reset       (reset),
    .bd_n_in     (bd_n_in),
    .bapr_n_in   (bapr_n_in),
    .bdap_n_in   (bdap_n_in),
    .binput_n_in (binput_n_in),
    .bd_n_out    (bd_n_out),
    .bdry_n_out  (bdry_n_out),
    .mem         (mem_bus.requester)
  );

  onboard_ram u_onboard_ram (
    .s_clk (s_clk),
    .reset (reset),
    .mem   (mem_bus.responder)
  );

endmodule

// ==== tb_nd_cpu_board.sv ====
// Testbench for the CPU board with bus-master tasks, reference memory,
// microword checks and bus assertions
`timescale 1ns/10ps

module tb_nd_cpu_board import nd_board_pkg::*; ();

  localparam int TIMEOUT = 20; // Cycles allowed per wait loop

  logic        s_clk = 1'b0;
  logic        reset;
  logic [63:0] csbits;
  bd_word_t    bd_n_in;
  logic        bapr_n_in;
  logic        bdap_n_in;
  logic        binput_n_in;
  bd_word_t    bd_n_out;
  logic        bdry_n_out;
  logic [8:0]  csalui;
  logic [1:0]  csalum;
  logic [4:0]  csidbs;
  logic [4:0]  cscomm;
  logic [1:0]  csdelay;
  logic [2:0]  csflags;
  logic [1:0]  mis;

  logic [31:0] rng_state = 32'd79268;  // Xorshift state
  data_word_t  ref_mem [ram_addr_t];   // Reference RAM contents
  int          errors    = 0;
  int          tests_ok  = 0;
  int          tests_bad = 0;

  always #2 s_clk = ~s_clk; // 4 ns period

  nd_cpu_board uut (.*);

  // ******************************
  // Bus assertions
  // ******************************
  bus_idle_check: assert property (@(posedge s_clk) disable iff (reset)
    bdry_n_out |-> (bd_n_out == '1))
  else
  begin
    errors++;
    $display("** Error: bd_n_out expected %h got %h", {BD_WIDTH{1'b1}}, $sampled(bd_n_out));
  end

  bus_upper_check: assert property (@(posedge s_clk) disable iff (reset)
    bd_n_out[BD_WIDTH-1:DATA_WIDTH] == '1)
  else
  begin
    errors++;
    $display("** Error: bd_n_out[23:16] expected ff got %h",
             $sampled(bd_n_out[BD_WIDTH-1:DATA_WIDTH]));
  end

  // ******************************
  // Helpers
  // ******************************
  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic bd_word_t make_addr(input logic [PAGE_WIDTH-1:0] page, input ram_addr_t word);
    logic [31:0] mid;
    mid = next_random(); // Don't-care bits 18:8
    return {page, mid[BD_WIDTH-PAGE_WIDTH-RAM_ADDR_WIDTH-1:0], word};
  endfunction

  task automatic step_clock();
    @(posedge s_clk);
    #1; // Drive and sample just after the edge
  endtask

  task automatic abort_run(input string reason);
    $display("Timeout: %s", reason);
    $display("tests failed");
    $finish;
  endtask

  task automatic check_value(input string sig, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp)
    else
    begin
      errors++;
      $display("** Error: %s expected %h got %h", sig, exp, got);
    end
  endtask

  // Wait for bdry_n_out to reach a level, then check the 3-cycle latency
  task automatic wait_bdry(input logic level, input string what);
    int n;
    n = 0;
    while (bdry_n_out !== level && n < TIMEOUT)
    begin
      step_clock();
      n++;
    end
    if (bdry_n_out !== level)
      abort_run({"bdry_n_out never reached the level for ", what});
    else
    begin
      // First step is the sampling edge
      check_value({"bdry_n_out latency, ", what}, 3, n - 1);
    end
  endtask

  // ******************************
  // Bus master
  // ******************************
  task automatic start_cycle(input bd_word_t addr);
    bd_n_in   = ~addr;
    bapr_n_in = 1'b0;
    step_clock(); // Address latched here
  endtask

  task automatic end_cycle();
    bapr_n_in = 1'b1;
    bd_n_in   = '1;
    step_clock();
  endtask

  task automatic write_word(input bd_word_t addr, input data_word_t data);
    start_cycle(addr);
    bd_n_in   = {{(BD_WIDTH-DATA_WIDTH){1'b1}}, ~data};
    bdap_n_in = 1'b0;
    wait_bdry(1'b0, "write ready");
    bdap_n_in = 1'b1;
    wait_bdry(1'b1, "write release");
    end_cycle();
  endtask

  task automatic read_word(input bd_word_t addr, input int hold, output data_word_t data);
    bd_word_t first;
    start_cycle(addr);
    binput_n_in = 1'b0;
    wait_bdry(1'b0, "read ready");
    first = bd_n_out;
    data  = ~first[DATA_WIDTH-1:0]; // Back to true polarity
    repeat (hold) // Master stalls with strobe low
    begin
      step_clock();
      check_value("bdry_n_out", 1'b0, bdry_n_out);
      check_value("bd_n_out", first, bd_n_out);
    end
    binput_n_in = 1'b1;
    wait_bdry(1'b1, "read release");
    end_cycle();
  endtask

  task automatic finish_test(input string name, input int errs_at_start);
    if (errors == errs_at_start)
    begin
      tests_ok++;
      $display("test %s: pass", name);
    end
    else
    begin
      tests_bad++;
      $display("test %s: fail, %0d errors", name, errors - errs_at_start);
    end
  endtask

  // ******************************
  // Test sequence
  // ******************************
  initial
  begin
    int                    mark;
    logic [31:0]           rnd;
    logic [63:0]           cur;
    logic [63:0]           prev;
    ram_addr_t             word;
    data_word_t            keep;
    data_word_t            got;
    logic [PAGE_WIDTH-1:0] page;

    reset       = 1'b1;
    csbits      = {next_random(), next_random()}; // Must be cleared by reset
    bd_n_in     = '1;
    bapr_n_in   = 1'b1;
    bdap_n_in   = 1'b1;
    binput_n_in = 1'b1;
    repeat (10) step_clock();
    reset  = 1'b0;
    csbits = '0;

    mark = errors; // Reset state
    check_value("bdry_n_out", 1'b1, bdry_n_out);
    check_value("bd_n_out", {BD_WIDTH{1'b1}}, bd_n_out);
    check_value("csalui", '0, csalui);
    check_value("csalum", '0, csalum);
    check_value("csidbs", '0, csidbs);
    check_value("cscomm", '0, cscomm);
    check_value("csdelay", '0, csdelay);
    check_value("csflags", '0, csflags);
    check_value("mis", '0, mis);
    finish_test("reset_state", mark);

    mark = errors; // Single write and read back
    rnd  = next_random();
    word = rnd[7:0];
    keep = rnd[31:16];
    write_word(make_addr(RAM_BASE_PAGE, word), keep);
    ref_mem[word] = keep;
    read_word(make_addr(RAM_BASE_PAGE, word), 0, got);
    check_value("read data ~bd_n_out[15:0]", keep, got);
    finish_test("write_read", mark);

    mark = errors; // Mixed traffic in a 32-word window
    repeat (40)
    begin
      rnd  = next_random();
      word = {3'b000, rnd[4:0]};
      if (rnd[8] || !ref_mem.exists(word))
      begin
        keep = rnd[31:16];
        write_word(make_addr(RAM_BASE_PAGE, word), keep);
        ref_mem[word] = keep;
      end
      else
      begin
        read_word(make_addr(RAM_BASE_PAGE, word), 0, got);
        check_value("read data ~bd_n_out[15:0]", ref_mem[word], got);
      end
    end
    finish_test("random_traffic", mark);

    mark = errors; // Off-page write must not land
    rnd  = next_random();
    word = rnd[7:0];
    keep = rnd[31:16];
    write_word(make_addr(RAM_BASE_PAGE, word), keep);
    ref_mem[word] = keep;
    page = rnd[12:8];
    if (page == RAM_BASE_PAGE)
      page = page + 5'd1;
    start_cycle(make_addr(page, word));
    bd_n_in   = {{(BD_WIDTH-DATA_WIDTH){1'b1}}, keep}; // Inverted data differs from keep
    bdap_n_in = 1'b0;
    repeat (TIMEOUT)
    begin
      step_clock();
      check_value("bdry_n_out", 1'b1, bdry_n_out);
      check_value("bd_n_out", {BD_WIDTH{1'b1}}, bd_n_out);
    end
    bdap_n_in = 1'b1;
    end_cycle();
    read_word(make_addr(RAM_BASE_PAGE, word), 0, got);
    check_value("read data ~bd_n_out[15:0]", ref_mem[word], got);
    finish_test("off_page", mark);

    mark = errors; // Held read strobe
    repeat (3)
    begin
      rnd  = next_random();
      word = rnd[7:0];
      keep = rnd[31:16];
      write_word(make_addr(RAM_BASE_PAGE, word), keep);
      ref_mem[word] = keep;
      read_word(make_addr(RAM_BASE_PAGE, word), 5 + int'(next_random() % 11), got);
      check_value("read data ~bd_n_out[15:0]", ref_mem[word], got);
    end
    finish_test("back_pressure", mark);

    mark = errors; // Back-to-back microwords
    prev = '0;
    for (int i = 0; i < 16; i++)
    begin
      cur    = {next_random(), next_random()};
      csbits = cur;
      step_clock();
      check_value("csalui", cur[63:55], csalui);
      check_value("csalum", cur[45:44], csalum);
      check_value("csidbs", cur[41:37], csidbs);
      check_value("cscomm", cur[36:32], cscomm);
      check_value("csdelay", cur[27:26], csdelay);
      check_value("csflags", cur[23:21], csflags);
      check_value("mis", prev[43:42], mis); // Two cycles behind csbits
      prev = cur;
    end
    step_clock();
    check_value("mis", prev[43:42], mis);
    finish_test("microword", mark);

    $display("summary: %0d tests run, %0d passed, %0d failed, %0d errors",
             tests_ok + tests_bad, tests_ok, tests_bad, errors);
    if (errors == 0 && tests_bad == 0)
    begin
      $display("all tests passed");
    end
    else
    begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
nd_board_pkg.sv
mem_req_if.sv
micro_word_reg.sv
nd_bus_slave.sv
onboard_ram.sv
nd_cpu_board.sv
tb_nd_cpu_board.sv

// ==== Bender.yml ====
package:
  name: nd_cpu_board

sources:
  - nd_board_pkg.sv
  - mem_req_if.sv
  - micro_word_reg.sv
  - nd_bus_slave.sv
  - onboard_ram.sv
  - nd_cpu_board.sv
  - target: simulation
    files:
      - tb_nd_cpu_board.sv
